// ==== verilog/dm_pkg.sv ====
// RISC-V debug specification definitions used by the debug module.
// Holds the DMI opcodes and response codes, the register map and the bit
// positions of the implemented dmcontrol, dmstatus and sbcs fields.
package dm_pkg;

  localparam int unsigned DmiAddrWidth = 7;

  // dmstatus version field, 2 means spec 0.13
  localparam logic [3:0] DmVersion = 4'd2;

  typedef enum logic [1:0] {
    DmiNop   = 2'h0,
    DmiRead  = 2'h1,
    DmiWrite = 2'h2
  } dmi_op_e;

  typedef enum logic [1:0] {
    DmiSuccess = 2'h0,
    DmiFailed  = 2'h2
  } dmi_resp_e;

  typedef enum logic [DmiAddrWidth-1:0] {
    Data0      = 7'h04,
    DmControl  = 7'h10,
    DmStatus   = 7'h11,
    Hartinfo   = 7'h12,
    Sbcs       = 7'h38,
    SbAddress0 = 7'h39,
    SbData0    = 7'h3C,
    HaltSum0   = 7'h40
  } dm_reg_e;

  // dmcontrol
  localparam int unsigned DmctlDmactive  = 0;
  localparam int unsigned DmctlNdmreset  = 1;
  localparam int unsigned DmctlHartselLo = 16;
  localparam int unsigned DmctlHaltreq   = 31;

  // dmstatus
  localparam int unsigned DmstAnyhalted  = 8;
  localparam int unsigned DmstAllhalted  = 9;
  localparam int unsigned DmstAnyunavail = 12;
  localparam int unsigned DmstAllunavail = 13;

  // sbcs, the error field is three bits wide
  localparam int unsigned SbcsAutoinc    = 16;
  localparam int unsigned SbcsReadonaddr = 20;
  localparam int unsigned SbcsBusy       = 21;
  localparam int unsigned SbcsBusyerror  = 22;
  localparam int unsigned SbcsError      = 12;

  // sberror code for an address that is not word aligned
  localparam logic [2:0] SbErrAlign = 3'd3;

  // sbversion 1, sbaccess fixed at 32 bit, sbasize 32, sbaccess32 supported
  localparam logic [31:0] SbcsStatic = (32'd1 << 29) | (32'd2 << 17) | (32'd32 << 5)
                                     | 32'h0000_0004;

endpackage

// ==== verilog/dbg_sys_pkg.sv ====
// System configuration of the debug subsystem.
// Fixes the hart slots, the system bus width and the capabilities that
// the debug module reports for every hart.
package dbg_sys_pkg;

  localparam int unsigned NrHarts      = 4;
  localparam int unsigned HartselWidth = 2;
  localparam int unsigned BusWidth     = 32;

  // hart 2 does not exist in this system
  localparam logic [NrHarts-1:0] SelectableHarts = 4'b1011;

  // nscratch [23:20], dataaccess [16], datasize [15:12], dataaddr [11:0]
  localparam logic [31:0] HartinfoValue = {8'h00, 4'd2, 3'b000, 1'b1, 4'd1, 12'h380};

endpackage

// ==== verilog/dm_csrs.sv ====
`timescale 1ns/1ps
// DMI register block of the debug module.
// Accepts one DMI request at a time, answers on the following edge and
// holds the response until the debugger takes it. Routes halt requests
// to the harts and hands system bus accesses to the bus engine.
module dm_csrs (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             dmi_req_valid_i,
  output logic                             dmi_req_ready_o,
  input  dm_pkg::dm_reg_e                  dmi_req_addr_i,
  input  dm_pkg::dmi_op_e                  dmi_req_op_i,
  input  logic [31:0]                      dmi_req_data_i,
  output logic                             dmi_resp_valid_o,
  input  logic                             dmi_resp_ready_i,
  output logic [31:0]                      dmi_resp_data_o,
  output dm_pkg::dmi_resp_e                dmi_resp_op_o,
  input  logic [dbg_sys_pkg::NrHarts-1:0]  hart_halted_i,
  output logic [dbg_sys_pkg::NrHarts-1:0]  debug_req_o,
  output logic                             ndmreset_req_o,
  output logic                             sba_start_o,
  output logic                             sba_we_o,
  output logic [dbg_sys_pkg::BusWidth-1:0] sba_addr_o,
  output logic [dbg_sys_pkg::BusWidth-1:0] sba_wdata_o,
  output logic                             sba_autoinc_o,
  input  logic                             sba_busy_i,
  input  logic                             sba_done_i,
  input  logic [dbg_sys_pkg::BusWidth-1:0] sba_rdata_i,
  input  logic [dbg_sys_pkg::BusWidth-1:0] sba_next_addr_i
);

  logic                                 req_take;
  logic                                 ready_q;
  logic                                 resp_valid_d, resp_valid_q;
  dm_pkg::dmi_resp_e                    resp_op_d, resp_op_q;
  logic [31:0]                          resp_data_q;
  logic [31:0]                          rdata;
  logic [31:0]                          data0_d, data0_q;
  logic                                 dmactive_d, dmactive_q;
  logic                                 ndmreset_d, ndmreset_q;
  logic                                 haltreq_d, haltreq_q;
  logic [dbg_sys_pkg::HartselWidth-1:0] hartsel_d, hartsel_q;
  logic                                 autoinc_d, autoinc_q;
  logic                                 readonaddr_d, readonaddr_q;
  logic                                 busyerror_d, busyerror_q;
  logic [2:0]                           sberror_d, sberror_q;
  logic [dbg_sys_pkg::BusWidth-1:0]     sbaddress_d, sbaddress_q;
  logic [dbg_sys_pkg::BusWidth-1:0]     sbdata_d, sbdata_q;
  logic                                 sb_read_d, sb_read_q;
  logic [dbg_sys_pkg::NrHarts-1:0]      debug_req_d, debug_req_q;
  logic                                 sel_halted;
  logic                                 sel_unavail;

  assign req_take         = dmi_req_valid_i & dmi_req_ready_o;
  assign dmi_req_ready_o  = ready_q;
  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_data_o  = resp_data_q;
  assign dmi_resp_op_o    = resp_op_q;
  assign debug_req_o      = debug_req_q;
  assign ndmreset_req_o   = ndmreset_q;
  assign sba_autoinc_o    = autoinc_q;

  // only one hart is selected at a time, so any and all agree
  assign sel_halted  = hart_halted_i[hartsel_q] & dbg_sys_pkg::SelectableHarts[hartsel_q];
  assign sel_unavail = ~dbg_sys_pkg::SelectableHarts[hartsel_q];

  // register read mux
  always_comb begin
    rdata = '0;
    case (dmi_req_addr_i)
      dm_pkg::Data0: rdata = data0_q;
      dm_pkg::DmControl: begin
        rdata[dm_pkg::DmctlHaltreq]  = haltreq_q;
        rdata[dm_pkg::DmctlHartselLo +: dbg_sys_pkg::HartselWidth] = hartsel_q;
        rdata[dm_pkg::DmctlNdmreset] = ndmreset_q;
        rdata[dm_pkg::DmctlDmactive] = dmactive_q;
      end
      dm_pkg::DmStatus: begin
        rdata[3:0]                    = dm_pkg::DmVersion;
        rdata[dm_pkg::DmstAnyhalted]  = sel_halted;
        rdata[dm_pkg::DmstAllhalted]  = sel_halted;
        rdata[dm_pkg::DmstAnyunavail] = sel_unavail;
        rdata[dm_pkg::DmstAllunavail] = sel_unavail;
      end
      dm_pkg::Hartinfo: rdata = dbg_sys_pkg::HartinfoValue;
      dm_pkg::HaltSum0: begin
        rdata[dbg_sys_pkg::NrHarts-1:0] = hart_halted_i & dbg_sys_pkg::SelectableHarts;
      end
      dm_pkg::Sbcs: begin
        rdata = dm_pkg::SbcsStatic;
        rdata[dm_pkg::SbcsBusyerror]  = busyerror_q;
        rdata[dm_pkg::SbcsBusy]       = sba_busy_i;
        rdata[dm_pkg::SbcsReadonaddr] = readonaddr_q;
        rdata[dm_pkg::SbcsAutoinc]    = autoinc_q;
        rdata[dm_pkg::SbcsError +: 3] = sberror_q;
      end
      dm_pkg::SbAddress0: rdata = sbaddress_q;
      dm_pkg::SbData0: rdata = sbdata_q;
      default: rdata = '0;
    endcase
  end

  // response code follows the request opcode
  always_comb begin
    case (dmi_req_op_i)
      dm_pkg::DmiNop, dm_pkg::DmiRead, dm_pkg::DmiWrite: resp_op_d = dm_pkg::DmiSuccess;
      default: resp_op_d = dm_pkg::DmiFailed;
    endcase
  end

  always_comb begin
    logic sb_touch;
    logic sb_access;
    sb_touch     = 1'b0;
    sb_access    = 1'b0;
    resp_valid_d = resp_valid_q;
    data0_d      = data0_q;
    dmactive_d   = dmactive_q;
    ndmreset_d   = ndmreset_q;
    haltreq_d    = haltreq_q;
    hartsel_d    = hartsel_q;
    autoinc_d    = autoinc_q;
    readonaddr_d = readonaddr_q;
    busyerror_d  = busyerror_q;
    sberror_d    = sberror_q;
    sbaddress_d  = sbaddress_q;
    sbdata_d     = sbdata_q;
    sb_read_d    = sb_read_q;
    sba_start_o  = 1'b0;
    sba_we_o     = 1'b0;
    sba_addr_o   = sbaddress_q;
    sba_wdata_o  = dmi_req_data_i;

    if (resp_valid_q && dmi_resp_ready_i) begin
      resp_valid_d = 1'b0;
    end
    if (req_take) begin
      resp_valid_d = 1'b1;
    end

    // finished bus access, no register write can collide while busy
    if (sba_done_i) begin
      sbaddress_d = sba_next_addr_i;
      if (sb_read_q) begin
        sbdata_d = sba_rdata_i;
      end
    end

    if (req_take && dmi_req_op_i == dm_pkg::DmiWrite) begin
      case (dmi_req_addr_i)
        dm_pkg::Data0: data0_d = dmi_req_data_i;
        dm_pkg::DmControl: begin
          dmactive_d = dmi_req_data_i[dm_pkg::DmctlDmactive];
          if (dmactive_d) begin
            ndmreset_d = dmi_req_data_i[dm_pkg::DmctlNdmreset];
            haltreq_d  = dmi_req_data_i[dm_pkg::DmctlHaltreq];
            hartsel_d  = dmi_req_data_i[dm_pkg::DmctlHartselLo +: dbg_sys_pkg::HartselWidth];
          end else begin
            ndmreset_d   = 1'b0;
            haltreq_d    = 1'b0;
            hartsel_d    = '0;
            autoinc_d    = 1'b0;
            readonaddr_d = 1'b0;
            busyerror_d  = 1'b0;
            sberror_d    = '0;
          end
        end
        dm_pkg::Sbcs: begin
          autoinc_d    = dmi_req_data_i[dm_pkg::SbcsAutoinc];
          readonaddr_d = dmi_req_data_i[dm_pkg::SbcsReadonaddr];
          // both error flags are write-one-to-clear
          if (dmi_req_data_i[dm_pkg::SbcsBusyerror]) begin
            busyerror_d = 1'b0;
          end
          if (|dmi_req_data_i[dm_pkg::SbcsError +: 3]) begin
            sberror_d = '0;
          end
        end
        dm_pkg::SbAddress0: begin
          sb_touch   = 1'b1;
          sb_access  = readonaddr_q;
          sba_addr_o = dmi_req_data_i;
          if (!sba_busy_i) begin
            sbaddress_d = dmi_req_data_i;
          end
        end
        dm_pkg::SbData0: begin
          sb_touch  = 1'b1;
          sb_access = 1'b1;
          sba_we_o  = 1'b1;
          if (!sba_busy_i) begin
            sbdata_d = dmi_req_data_i;
          end
        end
        default: ;
      endcase

      // no new access while the engine runs or an error is pending
      if (sb_touch && sba_busy_i) begin
        busyerror_d = 1'b1;
      end else if (sb_access && !busyerror_q && sberror_q == '0) begin
        if (sba_addr_o[1:0] != 2'b00) begin
          sberror_d = dm_pkg::SbErrAlign;
        end else begin
          sba_start_o = 1'b1;
          sb_read_d   = ~sba_we_o;
        end
      end
    end
  end

  // halt request from the registered dmcontrol fields
  always_comb begin
    debug_req_d = '0;
    if (dmactive_q && haltreq_q && dbg_sys_pkg::SelectableHarts[hartsel_q]) begin
      debug_req_d[hartsel_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q      <= 1'b0;
      resp_valid_q <= 1'b0;
      resp_op_q    <= dm_pkg::DmiSuccess;
      dmactive_q   <= 1'b0;
      ndmreset_q   <= 1'b0;
      haltreq_q    <= 1'b0;
      hartsel_q    <= '0;
      autoinc_q    <= 1'b0;
      readonaddr_q <= 1'b0;
      busyerror_q  <= 1'b0;
      sberror_q    <= '0;
      sb_read_q    <= 1'b0;
      debug_req_q  <= '0;
    end else begin
      ready_q      <= ~resp_valid_d;
      resp_valid_q <= resp_valid_d;
      if (req_take) begin
        resp_op_q <= resp_op_d;
      end
      dmactive_q   <= dmactive_d;
      ndmreset_q   <= ndmreset_d;
      haltreq_q    <= haltreq_d;
      hartsel_q    <= hartsel_d;
      autoinc_q    <= autoinc_d;
      readonaddr_q <= readonaddr_d;
      busyerror_q  <= busyerror_d;
      sberror_q    <= sberror_d;
      sb_read_q    <= sb_read_d;
      debug_req_q  <= debug_req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_take) begin
      resp_data_q <= rdata;
    end
    data0_q     <= data0_d;
    sbaddress_q <= sbaddress_d;
    sbdata_q    <= sbdata_d;
  end

endmodule

// ==== verilog/dm_sba.sv ====
`timescale 1ns/1ps
// System bus access engine of the debug module.
// Runs one word read or write per start pulse on the req/gnt/rvalid bus and
// reports completion with a done pulse, the read data and the next address.
module dm_sba (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               sba_start_i,
  input  logic                               sba_we_i,
  input  logic [dbg_sys_pkg::BusWidth-1:0]   sba_addr_i,
  input  logic [dbg_sys_pkg::BusWidth-1:0]   sba_wdata_i,
  input  logic                               sba_autoinc_i,
  output logic                               sba_busy_o,
  output logic                               sba_done_o,
  output logic [dbg_sys_pkg::BusWidth-1:0]   sba_rdata_o,
  output logic [dbg_sys_pkg::BusWidth-1:0]   sba_next_addr_o,
  output logic                               sb_req_o,
  output logic                               sb_we_o,
  output logic [dbg_sys_pkg::BusWidth-1:0]   sb_addr_o,
  output logic [dbg_sys_pkg::BusWidth/8-1:0] sb_be_o,
  output logic [dbg_sys_pkg::BusWidth-1:0]   sb_wdata_o,
  input  logic                               sb_gnt_i,
  input  logic                               sb_rvalid_i,
  input  logic [dbg_sys_pkg::BusWidth-1:0]   sb_rdata_i
);

  typedef enum logic [1:0] {
    Idle,
    Request,
    WaitResp
  } state_e;

  state_e                           state_q;
  logic                             done_q;
  logic                             we_q;
  logic                             autoinc_q;
  logic [dbg_sys_pkg::BusWidth-1:0] addr_q;
  logic [dbg_sys_pkg::BusWidth-1:0] wdata_q;
  logic [dbg_sys_pkg::BusWidth-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        Idle: begin
          if (sba_start_i) begin
            state_q <= Request;
          end
        end
        // request stays up until the bus grants it
        Request: begin
          if (sb_gnt_i) begin
            state_q <= WaitResp;
          end
        end
        WaitResp: begin
          if (sb_rvalid_i) begin
            state_q <= Idle;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // operation captured at start, read data at the response
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && sba_start_i) begin
      we_q      <= sba_we_i;
      addr_q    <= sba_addr_i;
      wdata_q   <= sba_wdata_i;
      autoinc_q <= sba_autoinc_i;
    end
    if (state_q == WaitResp && sb_rvalid_i && !we_q) begin
      rdata_q <= sb_rdata_i;
    end
  end

  assign sb_req_o   = (state_q == Request);
  assign sb_we_o    = we_q;
  assign sb_addr_o  = addr_q;
  assign sb_wdata_o = wdata_q;
  assign sb_be_o    = '1;

  // busy covers the done cycle so no new access overlaps the write-back
  assign sba_busy_o      = (state_q != Idle) | done_q;
  assign sba_done_o      = done_q;
  assign sba_rdata_o     = rdata_q;
  assign sba_next_addr_o = autoinc_q
                         ? addr_q + dbg_sys_pkg::BusWidth'(dbg_sys_pkg::BusWidth / 8)
                         : addr_q;

endmodule

// ==== verilog/dm_rst_gen.sv ====
`timescale 1ns/1ps
// Non-debug reset generator.
// Merges the system reset with the dmcontrol ndmreset request, masked in
// test mode, and releases the result through a two-flop synchronizer.
module dm_rst_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic ndmreset_req_i,
  output logic ndmreset_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // in test mode only the system reset reaches the harts
  assign rst_comb_n = rst_ni & (test_en_i | ~ndmreset_req_i);

  // assert at once, release two edges after the cause is gone
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign ndmreset_no = sync_q[1];

endmodule

// ==== verilog/debug_system.sv ====
`timescale 1ns/1ps
// Top level of the external debug subsystem.
// The debugger drives the DMI port directly, system bus accesses leave on
// the native req/gnt/rvalid port and ndmreset_no resets the rest of the SoC.
module debug_system (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               test_en_i,
  output logic                               ndmreset_no,
  input  logic                               dmi_req_valid_i,
  output logic                               dmi_req_ready_o,
  input  dm_pkg::dm_reg_e                    dmi_req_addr_i,
  input  dm_pkg::dmi_op_e                    dmi_req_op_i,
  input  logic [31:0]                        dmi_req_data_i,
  output logic                               dmi_resp_valid_o,
  input  logic                               dmi_resp_ready_i,
  output logic [31:0]                        dmi_resp_data_o,
  output dm_pkg::dmi_resp_e                  dmi_resp_op_o,
  input  logic [dbg_sys_pkg::NrHarts-1:0]    hart_halted_i,
  output logic [dbg_sys_pkg::NrHarts-1:0]    debug_req_o,
  output logic                               sb_req_o,
  output logic                               sb_we_o,
  output logic [dbg_sys_pkg::BusWidth-1:0]   sb_addr_o,
  output logic [dbg_sys_pkg::BusWidth/8-1:0] sb_be_o,
  output logic [dbg_sys_pkg::BusWidth-1:0]   sb_wdata_o,
  input  logic                               sb_gnt_i,
  input  logic                               sb_rvalid_i,
  input  logic [dbg_sys_pkg::BusWidth-1:0]   sb_rdata_i
);

  // register block to bus engine
  logic                             sba_start;
  logic                             sba_we;
  logic [dbg_sys_pkg::BusWidth-1:0] sba_addr;
  logic [dbg_sys_pkg::BusWidth-1:0] sba_wdata;
  logic                             sba_autoinc;
  logic                             sba_busy;
  logic                             sba_done;
  logic [dbg_sys_pkg::BusWidth-1:0] sba_rdata;
  logic [dbg_sys_pkg::BusWidth-1:0] sba_next_addr;
  logic                             ndmreset_req;

  dm_csrs i_dm_csrs (
    .clk_i,
    .rst_ni,
    .dmi_req_valid_i,
    .dmi_req_ready_o,
    .dmi_req_addr_i,
    .dmi_req_op_i,
    .dmi_req_data_i,
    .dmi_resp_valid_o,
    .dmi_resp_ready_i,
    .dmi_resp_data_o,
    .dmi_resp_op_o,
    .hart_halted_i,
    .debug_req_o,
    .ndmreset_req_o  (ndmreset_req),
    .sba_start_o     (sba_start),
    .sba_we_o        (sba_we),
    .sba_addr_o      (sba_addr),
    .sba_wdata_o     (sba_wdata),
    .sba_autoinc_o   (sba_autoinc),
    .sba_busy_i      (sba_busy),
    .sba_done_i      (sba_done),
    .sba_rdata_i     (sba_rdata),
    .sba_next_addr_i (sba_next_addr)
  );

  dm_sba i_dm_sba (
    .clk_i,
    .rst_ni,
    .sba_start_i     (sba_start),
    .sba_we_i        (sba_we),
    .sba_addr_i      (sba_addr),
    .sba_wdata_i     (sba_wdata),
    .sba_autoinc_i   (sba_autoinc),
    .sba_busy_o      (sba_busy),
    .sba_done_o      (sba_done),
    .sba_rdata_o     (sba_rdata),
    .sba_next_addr_o (sba_next_addr),
    .sb_req_o,
    .sb_we_o,
    .sb_addr_o,
    .sb_be_o,
    .sb_wdata_o,
    .sb_gnt_i,
    .sb_rvalid_i,
    .sb_rdata_i
  );

  dm_rst_gen i_dm_rst_gen (
    .clk_i,
    .rst_ni,
    .test_en_i,
    .ndmreset_req_i (ndmreset_req),
    .ndmreset_no
  );

endmodule

// ==== tests/tb_debug_system.sv ====
`timescale 1ns/1ps
// Testbench for the debug subsystem top level.
// Drives the DMI port with random stimulus, answers system bus requests from a
// sparse memory, models hart halting and checks responses against a local model.
module tb_debug_system;

  localparam int unsigned NrHarts        = dbg_sys_pkg::NrHarts;
  localparam int unsigned NrTransactions = 200;
  localparam int unsigned CyclesPerTrans = 20;
  localparam int unsigned MaxCycles      = NrTransactions * CyclesPerTrans;

  logic               clk_i;
  logic               rst_ni;
  logic               test_en_i;
  logic               ndmreset_no;
  logic               dmi_req_valid_i;
  logic               dmi_req_ready_o;
  dm_pkg::dm_reg_e    dmi_req_addr_i;
  dm_pkg::dmi_op_e    dmi_req_op_i;
  logic [31:0]        dmi_req_data_i;
  logic               dmi_resp_valid_o;
  logic               dmi_resp_ready_i;
  logic [31:0]        dmi_resp_data_o;
  dm_pkg::dmi_resp_e  dmi_resp_op_o;
  logic [NrHarts-1:0] hart_halted_i;
  logic [NrHarts-1:0] debug_req_o;
  logic               sb_req_o;
  logic               sb_we_o;
  logic [31:0]        sb_addr_o;
  logic [3:0]         sb_be_o;
  logic [31:0]        sb_wdata_o;
  logic               sb_gnt_i;
  logic               sb_rvalid_i;
  logic [31:0]        sb_rdata_i;

  int unsigned errors;
  int unsigned checks;
  int unsigned cycle_cnt;
  int unsigned bus_xfers;
  int unsigned gnt_wait;
  logic        bp_en;
  logic        harts_frozen;
  logic        gnt_we;
  logic [31:0] gnt_addr;
  logic [31:0] bus_mem [logic [31:0]];
  logic [31:0] exp_mem [logic [31:0]];
  logic [31:0] written_q [$];

  debug_system i_debug_system (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // untouched memory returns a word derived from its address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr);
  endfunction

  function automatic logic [31:0] stored_word(input logic [31:0] addr);
    return bus_mem.exists(addr) ? bus_mem[addr] : 32'hx;
  endfunction

  function automatic logic [31:0] dmstatus_model(input int unsigned hart,
                                                 input logic [NrHarts-1:0] halted);
    logic [31:0] word;
    logic        unavail;
    unavail = ~dbg_sys_pkg::SelectableHarts[hart];
    word    = 32'(dm_pkg::DmVersion);
    word[dm_pkg::DmstAnyhalted]  = halted[hart] & ~unavail;
    word[dm_pkg::DmstAllhalted]  = halted[hart] & ~unavail;
    word[dm_pkg::DmstAnyunavail] = unavail;
    word[dm_pkg::DmstAllunavail] = unavail;
    return word;
  endfunction

  function automatic logic [31:0] sbcs_model(input logic autoinc, input logic readonaddr,
                                             input logic busyerror);
    logic [31:0] word;
    word = dm_pkg::SbcsStatic;
    word[dm_pkg::SbcsAutoinc]    = autoinc;
    word[dm_pkg::SbcsReadonaddr] = readonaddr;
    word[dm_pkg::SbcsBusyerror]  = busyerror;
    return word;
  endfunction

  task automatic compare_data(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_resp(input dm_pkg::dmi_resp_e got, input dm_pkg::dmi_resp_e exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %0d, expected %s", $time, what, got, exp.name());
    end
  endtask

  task automatic compare_harts(input logic [NrHarts-1:0] got, input logic [NrHarts-1:0] exp,
                               input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // called and returns on a falling edge
  task automatic dmi_access(input dm_pkg::dm_reg_e addr, input dm_pkg::dmi_op_e op,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output dm_pkg::dmi_resp_e resp);
    logic done;
    done            = 1'b0;
    dmi_req_valid_i = 1'b1;
    dmi_req_addr_i  = addr;
    dmi_req_op_i    = op;
    dmi_req_data_i  = wdata;
    while (!dmi_req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    dmi_req_valid_i = 1'b0;
    while (!done) begin
      if (dmi_resp_valid_o) begin
        rdata            = dmi_resp_data_o;
        resp             = dmi_resp_op_o;
        dmi_resp_ready_i = bp_en ? ($urandom_range(2, 0) != 0) : 1'b1;
        done             = dmi_resp_ready_i;
      end
      @(negedge clk_i);
    end
    dmi_resp_ready_i = 1'b0;
  endtask

  task automatic dmi_write(input dm_pkg::dm_reg_e addr, input logic [31:0] data);
    logic [31:0]       rd_ignored;
    dm_pkg::dmi_resp_e resp;
    dmi_access(addr, dm_pkg::DmiWrite, data, rd_ignored, resp);
    compare_resp(resp, dm_pkg::DmiSuccess, $sformatf("%s write response", addr.name()));
  endtask

  task automatic dmi_read(input dm_pkg::dm_reg_e addr, output logic [31:0] data);
    dm_pkg::dmi_resp_e resp;
    dmi_access(addr, dm_pkg::DmiRead, 32'h0, data, resp);
    compare_resp(resp, dm_pkg::DmiSuccess, $sformatf("%s read response", addr.name()));
  endtask

  task automatic wait_sba_idle();
    logic [31:0] sbcs;
    sbcs = '1;
    while (sbcs[dm_pkg::SbcsBusy]) dmi_read(dm_pkg::Sbcs, sbcs);
  endtask

  // bus memory that grants after 0 to 3 cycles and answers one cycle later
  always begin
    @(negedge clk_i);
    if (sb_req_o) begin
      gnt_wait = $urandom_range(3, 0);
      repeat (gnt_wait) @(negedge clk_i);
      sb_gnt_i = 1'b1;
      gnt_we   = sb_we_o;
      gnt_addr = sb_addr_o;
      compare_data({28'b0, sb_be_o}, 32'h0000_000f, "sb_be_o at grant");
      if (gnt_we) begin
        bus_mem[gnt_addr] = sb_wdata_o;
      end
      bus_xfers++;
      @(negedge clk_i);
      sb_gnt_i    = 1'b0;
      sb_rvalid_i = 1'b1;
      sb_rdata_i  = bus_mem.exists(gnt_addr) ? bus_mem[gnt_addr] : fill_word(gnt_addr);
      @(negedge clk_i);
      sb_rvalid_i = 1'b0;
    end
  end

  // harts halt a few cycles after a request and resume at random once it drops
  always @(negedge clk_i) begin
    if (rst_ni && !harts_frozen) begin
      for (int h = 0; h < NrHarts; h++) begin
        if (debug_req_o[h] && !hart_halted_i[h] && $urandom_range(2, 0) == 0) begin
          hart_halted_i[h] <= 1'b1;
        end else if (!debug_req_o[h] && hart_halted_i[h] && $urandom_range(3, 0) == 0) begin
          hart_halted_i[h] <= 1'b0;
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0]        rd;
    logic [31:0]        wd;
    logic [31:0]        addr;
    logic [31:0]        data0_model;
    logic [NrHarts-1:0] exp_req;
    logic [NrHarts-1:0] halted_snap;
    int unsigned        hs;
    int unsigned        xfers;
    void'($urandom(32'h87474c46));
    errors           = 0;
    checks           = 0;
    bus_xfers        = 0;
    bp_en            = 1'b1;
    harts_frozen     = 1'b0;
    rst_ni           = 1'b0;
    test_en_i        = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_addr_i   = dm_pkg::Data0;
    dmi_req_op_i     = dm_pkg::DmiNop;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b0;
    hart_halted_i    = '0;
    sb_gnt_i         = 1'b0;
    sb_rvalid_i      = 1'b0;
    sb_rdata_i       = '0;
    repeat (16) @(negedge clk_i);
    // handshake and bus outputs stay low while reset is held
    compare_data({29'b0, dmi_req_ready_o, dmi_resp_valid_o, sb_req_o}, 32'd0,
                 "ready, response valid and bus request in reset");
    compare_data({31'b0, ndmreset_no}, 32'd0, "ndmreset_no in reset");
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);

    // reset values
    compare_data({31'b0, ndmreset_no}, 32'd1, "ndmreset_no after reset");
    compare_harts(debug_req_o, '0, "debug_req_o after reset");
    dmi_read(dm_pkg::DmControl, rd);
    compare_data(rd, 32'h0, "dmcontrol after reset");
    dmi_read(dm_pkg::DmStatus, rd);
    compare_data(rd, dmstatus_model(0, '0), "dmstatus after reset");
    dmi_read(dm_pkg::Sbcs, rd);
    compare_data(rd, sbcs_model(1'b0, 1'b0, 1'b0), "sbcs after reset");
    dmi_read(dm_pkg::Hartinfo, rd);
    compare_data(rd, dbg_sys_pkg::HartinfoValue, "hartinfo");

    // data0 under random response back-pressure
    data0_model = $urandom();
    dmi_write(dm_pkg::Data0, data0_model);
    repeat (24) begin
      if ($urandom_range(1, 0) == 1) begin
        data0_model = $urandom();
        dmi_write(dm_pkg::Data0, data0_model);
      end else begin
        dmi_read(dm_pkg::Data0, rd);
        compare_data(rd, data0_model, "data0");
      end
    end
    dmi_read(dm_pkg::Data0, rd);
    compare_data(rd, data0_model, "data0");

    // halt routing to random harts
    repeat (8) begin
      hs = $urandom_range(NrHarts - 1, 0);
      dmi_write(dm_pkg::DmControl, (32'd1 << dm_pkg::DmctlHaltreq)
                                   | (32'(hs) << dm_pkg::DmctlHartselLo) | 32'd1);
      exp_req = '0;
      if (dbg_sys_pkg::SelectableHarts[hs]) begin
        exp_req[hs] = 1'b1;
      end
      compare_harts(debug_req_o, exp_req, "debug_req_o");
      if (exp_req != '0) begin
        while (!hart_halted_i[hs]) @(negedge clk_i);
      end
      harts_frozen = 1'b1;
      @(negedge clk_i);
      halted_snap = hart_halted_i;
      dmi_read(dm_pkg::DmStatus, rd);
      compare_data(rd, dmstatus_model(hs, halted_snap), "dmstatus");
      dmi_read(dm_pkg::HaltSum0, rd);
      compare_harts(rd[NrHarts-1:0], halted_snap & dbg_sys_pkg::SelectableHarts, "haltsum0");
      harts_frozen = 1'b0;
    end
    dmi_write(dm_pkg::DmControl, 32'h0);
    compare_harts(debug_req_o, '0, "debug_req_o after dmactive cleared");
    dmi_read(dm_pkg::DmControl, rd);
    compare_data(rd, 32'h0, "dmcontrol after dmactive cleared");

    // bus writes through sbdata0 followed by reads on address write
    dmi_write(dm_pkg::DmControl, 32'd1);
    dmi_write(dm_pkg::Sbcs, 32'h0);
    repeat (6) begin
      addr = $urandom() & 32'hffff_fffc;
      wd   = $urandom();
      dmi_write(dm_pkg::SbAddress0, addr);
      dmi_write(dm_pkg::SbData0, wd);
      wait_sba_idle();
      exp_mem[addr] = wd;
      written_q.push_back(addr);
      compare_data(stored_word(addr), wd, "memory after sbdata0 write");
    end
    dmi_write(dm_pkg::Sbcs, 32'd1 << dm_pkg::SbcsReadonaddr);
    repeat (6) begin
      if ($urandom_range(1, 0) == 1) begin
        addr = written_q[$urandom_range(written_q.size() - 1, 0)];
      end else begin
        addr = $urandom() & 32'hffff_fffc;
      end
      dmi_write(dm_pkg::SbAddress0, addr);
      wait_sba_idle();
      dmi_read(dm_pkg::SbData0, rd);
      compare_data(rd, model_word(addr), "sbdata0 after bus read");
    end

    // autoincrement followed by a write while busy
    dmi_write(dm_pkg::Sbcs, 32'd1 << dm_pkg::SbcsAutoinc);
    addr = $urandom() & 32'h7fff_fff0;
    dmi_write(dm_pkg::SbAddress0, addr);
    for (int i = 0; i < 3; i++) begin
      wd = $urandom();
      dmi_write(dm_pkg::SbData0, wd);
      wait_sba_idle();
      exp_mem[addr + 32'(4 * i)] = wd;
      compare_data(stored_word(addr + 32'(4 * i)), wd, "memory after autoincrement write");
    end
    dmi_read(dm_pkg::SbAddress0, rd);
    compare_data(rd, addr + 32'd12, "sbaddress0 after autoincrement");
    // back-to-back requests so the second one lands while the engine runs
    bp_en = 1'b0;
    xfers = bus_xfers;
    wd    = $urandom();
    dmi_write(dm_pkg::SbData0, wd);
    dmi_write(dm_pkg::SbData0, ~wd);
    bp_en = 1'b1;
    wait_sba_idle();
    compare_data(32'(bus_xfers - xfers), 32'd1, "bus transfers for two writes while busy");
    compare_data(stored_word(addr + 32'd12), wd, "memory after rejected write");
    dmi_read(dm_pkg::Sbcs, rd);
    compare_data(rd, sbcs_model(1'b1, 1'b0, 1'b1), "sbcs with busyerror");
    dmi_write(dm_pkg::Sbcs, (32'd1 << dm_pkg::SbcsAutoinc) | (32'd1 << dm_pkg::SbcsBusyerror));
    dmi_read(dm_pkg::Sbcs, rd);
    compare_data(rd, sbcs_model(1'b1, 1'b0, 1'b0), "sbcs after busyerror clear");

    // non-debug reset in normal and test mode
    dmi_write(dm_pkg::Sbcs, 32'h0);
    dmi_write(dm_pkg::DmControl, 32'd3);
    compare_data({31'b0, ndmreset_no}, 32'd0, "ndmreset_no with ndmreset set");
    dmi_write(dm_pkg::DmControl, 32'd1);
    repeat (2) @(negedge clk_i);
    compare_data({31'b0, ndmreset_no}, 32'd1, "ndmreset_no after ndmreset cleared");
    test_en_i = 1'b1;
    dmi_write(dm_pkg::DmControl, 32'd3);
    repeat (2) @(negedge clk_i);
    compare_data({31'b0, ndmreset_no}, 32'd1, "ndmreset_no in test mode");
    dmi_write(dm_pkg::DmControl, 32'd1);
    test_en_i = 1'b0;
    repeat (2) @(negedge clk_i);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
verilog/dm_pkg.sv
verilog/dbg_sys_pkg.sv
verilog/dm_csrs.sv
verilog/dm_sba.sv
verilog/dm_rst_gen.sv
verilog/debug_system.sv
tests/tb_debug_system.sv

// ==== Bender.yml ====
package:
  name: debug_system

dependencies: {}

sources:
  # packages first, then the design bottom-up
  - verilog/dm_pkg.sv
  - verilog/dbg_sys_pkg.sv
  - verilog/dm_csrs.sv
  - verilog/dm_sba.sv
  - verilog/dm_rst_gen.sv
  - verilog/debug_system.sv

  - target: simulation
    files:
      - tests/tb_debug_system.sv
